/* mem_region_top.f */
common/mem_region_pkg.sv
logic/lsu_demux.sv
data_ram/data_sp_ram.sv
data_ram/data_ram_mux.sv
logic/mem_region_top.sv
verif/mem_region_assert.sv
verif/tb_mem_region.sv

/* verif/tb_mem_region.sv */
`timescale 1ns/1ps

module tb_mem_region;

  localparam int RAM_ADDR_W = 8;
  localparam int MAX_ROWS   = 32;
  localparam int PORT_LSU   = 0;
  localparam int PORT_LD    = 1;
  localparam int PORT_BOTH  = 2;
  localparam logic [11:0] LOCAL_REGION = 12'h001;

  logic                  clk;
  logic                  rst_n;
  logic                  lsu_req_i;
  mem_region_pkg::addr_t lsu_addr_i;
  logic                  lsu_we_i;
  mem_region_pkg::be_t   lsu_be_i;
  mem_region_pkg::data_t lsu_wdata_i;
  logic                  lsu_gnt_o;
  logic                  lsu_rvalid_o;
  mem_region_pkg::data_t lsu_rdata_o;
  logic                  ext_req_o;
  mem_region_pkg::addr_t ext_addr_o;
  logic                  ext_we_o;
  mem_region_pkg::be_t   ext_be_o;
  mem_region_pkg::data_t ext_wdata_o;
  logic                  ext_gnt_i;
  logic                  ext_rvalid_i;
  mem_region_pkg::data_t ext_rdata_i;
  logic                  ld_req_i;
  logic [RAM_ADDR_W-1:0] ld_addr_i;
  logic                  ld_we_i;
  mem_region_pkg::be_t   ld_be_i;
  mem_region_pkg::data_t ld_wdata_i;
  mem_region_pkg::data_t ld_rdata_o;

  // Stimulus table, one entry per request or burst
  int                    row_port  [MAX_ROWS];
  logic                  row_we    [MAX_ROWS];
  mem_region_pkg::addr_t row_addr  [MAX_ROWS];
  mem_region_pkg::be_t   row_be    [MAX_ROWS];
  mem_region_pkg::data_t row_wdata [MAX_ROWS];
  mem_region_pkg::data_t row_exp   [MAX_ROWS];
  int                    row_len   [MAX_ROWS];
  int                    row_count = 0;

  mem_region_pkg::data_t ref_mem [2**RAM_ADDR_W];
  int unsigned           gnt_delay [16];
  int unsigned           rsp_delay [16];
  int                    ext_count   = 0;
  int                    error_count = 0;
  int                    check_count = 0;
  int                    cycle_count = 0;
  int                    max_cycles  = 20 * MAX_ROWS + 10;

  mem_region_top #(.RAM_ADDR_W(RAM_ADDR_W)) i_dut (.*);

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > max_cycles)
    begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  // External bus: grant after a few idle cycles, answer one to three cycles later
  always
  begin : ext_bus_model
    mem_region_pkg::addr_t req_addr;
    @(negedge clk);
    if (rst_n && ext_req_o)
    begin
      req_addr = ext_addr_o;
      repeat (gnt_delay[ext_count % 16]) @(posedge clk);
      @(posedge clk);
      #2;
      ext_gnt_i = 1'b1;
      @(posedge clk);
      #2;
      ext_gnt_i = 1'b0;
      repeat (rsp_delay[ext_count % 16])
      begin
        @(posedge clk);
        #2;
      end
      ext_rvalid_i = 1'b1;
      ext_rdata_i  = ~req_addr;
      @(posedge clk);
      #2;
      ext_rvalid_i = 1'b0;
      ext_count++;
    end
  end

  task automatic check_data(input string name, input mem_region_pkg::data_t exp,
                            input mem_region_pkg::data_t act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input mem_region_pkg::addr_t exp,
                            input mem_region_pkg::addr_t act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_be(input string name, input mem_region_pkg::be_t exp,
                          input mem_region_pkg::be_t act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_ctrl(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic table_mismatch(input mem_region_pkg::addr_t addr,
                                input mem_region_pkg::data_t exp,
                                input mem_region_pkg::data_t model);
    error_count++;
    $display("Table row for address %h expects %h but the reference memory holds %h",
             addr, exp, model);
  endtask

  // Byte-enable merge into the reference memory
  task automatic model_write(input logic [RAM_ADDR_W-1:0] word, input mem_region_pkg::be_t be,
                             input mem_region_pkg::data_t wdata);
    for (int b = 0; b < 4; b++)
      if (be[b])
        ref_mem[word][8*b +: 8] = wdata[8*b +: 8];
  endtask

  task automatic add_row(input int port, input logic we, input mem_region_pkg::addr_t addr,
                         input mem_region_pkg::be_t be, input mem_region_pkg::data_t wdata,
                         input mem_region_pkg::data_t exp, input int len);
    row_port[row_count]  = port;
    row_we[row_count]    = we;
    row_addr[row_count]  = addr;
    row_be[row_count]    = be;
    row_wdata[row_count] = wdata;
    row_exp[row_count]   = exp;
    row_len[row_count]   = len;
    row_count++;
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic ld_access(input mem_region_pkg::addr_t addr, input logic we,
                           input mem_region_pkg::be_t be, input mem_region_pkg::data_t wdata,
                           input mem_region_pkg::data_t exp);
    logic [RAM_ADDR_W-1:0] word;
    mem_region_pkg::data_t exp_word;
    word       = addr[RAM_ADDR_W+1:2];
    ld_req_i   = 1'b1;
    ld_addr_i  = word;
    ld_we_i    = we;
    ld_be_i    = be;
    ld_wdata_i = wdata;
    @(negedge clk);
    exp_word = ref_mem[word];
    if (we)
      model_write(word, be, wdata);
    else if (exp_word !== exp)
      table_mismatch(addr, exp, exp_word);
    @(posedge clk);
    #2;
    ld_req_i = 1'b0;
    ld_we_i  = 1'b0;
    if (!we)
    begin
      @(negedge clk);
      check_data("ld_rdata_o", exp_word, ld_rdata_o);
      @(posedge clk);
      #2;
    end
  endtask

  // Issues len requests on consecutive words and collects their responses
  task automatic lsu_access(input mem_region_pkg::addr_t addr, input logic we,
                            input mem_region_pkg::be_t be, input mem_region_pkg::data_t wdata,
                            input int len, input mem_region_pkg::data_t exp_first);
    mem_region_pkg::data_t exp_q [$];
    logic                  chk_q [$];
    mem_region_pkg::addr_t cur_addr;
    mem_region_pkg::data_t exp_word;
    logic                  local_req;
    logic                  accepted;
    logic                  prev_accepted;
    int                    issued;
    int                    received;
    issued        = 0;
    received      = 0;
    prev_accepted = 1'b0;
    cur_addr      = addr;
    local_req     = (addr[31:20] == LOCAL_REGION);
    lsu_req_i     = 1'b1;
    lsu_addr_i    = cur_addr;
    lsu_we_i      = we;
    lsu_be_i      = be;
    lsu_wdata_i   = wdata;
    while (received < len)
    begin
      @(negedge clk);
      if (local_req)
        check_ctrl("lsu_rvalid_o", prev_accepted, lsu_rvalid_o);
      if (lsu_rvalid_o)
      begin
        received++;
        if (exp_q.size() == 0)
        begin
          error_count++;
          $display("Response at %0t ns arrived with no LSU request outstanding", $time);
        end
        else
        begin
          exp_word = exp_q.pop_front();
          if (chk_q.pop_front())
            check_data("lsu_rdata_o", exp_word, lsu_rdata_o);
        end
      end
      if (lsu_req_i && local_req)
      begin
        check_ctrl("ext_req_o", 1'b0, ext_req_o);
        check_ctrl("lsu_gnt_o", !ld_req_i, lsu_gnt_o);
      end
      else if (lsu_req_i)
      begin
        check_ctrl("ext_req_o", 1'b1, ext_req_o);
        check_addr("ext_addr_o", cur_addr, ext_addr_o);
        check_ctrl("ext_we_o", we, ext_we_o);
        check_be("ext_be_o", be, ext_be_o);
        check_data("ext_wdata_o", wdata, ext_wdata_o);
        check_ctrl("lsu_gnt_o", ext_gnt_i, lsu_gnt_o);
      end
      accepted = lsu_req_i && lsu_gnt_o;
      if (accepted)
      begin
        exp_word = local_req ? ref_mem[cur_addr[RAM_ADDR_W+1:2]] : ~cur_addr;
        if (we && local_req)
          model_write(cur_addr[RAM_ADDR_W+1:2], be, wdata);
        if (!we && issued == 0 && exp_word !== exp_first)
          table_mismatch(cur_addr, exp_first, exp_word);
        exp_q.push_back(exp_word);
        chk_q.push_back(!we);
      end
      prev_accepted = accepted;
      @(posedge clk);
      #2;
      if (accepted)
      begin
        issued++;
        cur_addr   = cur_addr + 4;
        lsu_addr_i = cur_addr;
        if (issued == len)
          lsu_req_i = 1'b0;
      end
    end
  endtask

  initial
  begin
    int unsigned seed_val;
    clk          = 1'b0;
    rst_n        = 1'b0;
    lsu_req_i    = 1'b0;
    lsu_addr_i   = '0;
    lsu_we_i     = 1'b0;
    lsu_be_i     = '0;
    lsu_wdata_i  = '0;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    ld_req_i     = 1'b0;
    ld_addr_i    = '0;
    ld_we_i      = 1'b0;
    ld_be_i      = '0;
    ld_wdata_i   = '0;
    seed_val = $urandom(11);
    for (int i = 0; i < 16; i++)
    begin
      gnt_delay[i] = $urandom_range(3, 0);
      rsp_delay[i] = $urandom_range(2, 0);
    end

    // Loader fills words, LSU reads them back
    add_row(PORT_LD,  1'b1, 32'h0010_0000, 4'hF, 32'h1122_3344, '0, 1);
    add_row(PORT_LD,  1'b1, 32'h0010_0004, 4'hF, 32'hA5A5_A5A5, '0, 1);
    add_row(PORT_LD,  1'b1, 32'h0010_0000, 4'h5, 32'hFFEE_DDCC, '0, 1);
    add_row(PORT_LD,  1'b1, 32'h0010_0004, 4'hA, 32'h1234_5678, '0, 1);
    add_row(PORT_LD,  1'b1, 32'h0010_0008, 4'hF, 32'h55AA_00FF, '0, 1);
    add_row(PORT_LD,  1'b1, 32'h0010_000C, 4'hF, 32'h0F1E_2D3C, '0, 1);
    add_row(PORT_LSU, 1'b0, 32'h0010_0000, 4'hF, '0, 32'h11EE_33CC, 1);
    add_row(PORT_LSU, 1'b0, 32'h0010_0004, 4'hF, '0, 32'h12A5_56A5, 1);
    // LSU writes, loader reads
    add_row(PORT_LSU, 1'b1, 32'h0010_0010, 4'hF, 32'hCAFE_F00D, '0, 1);
    add_row(PORT_LSU, 1'b1, 32'h0010_0010, 4'h3, 32'h0000_1234, '0, 1);
    add_row(PORT_LSU, 1'b1, 32'h0010_0014, 4'hF, 32'h0BAD_BEEF, '0, 1);
    add_row(PORT_LSU, 1'b1, 32'h0010_0014, 4'hC, 32'h7E57_0000, '0, 1);
    add_row(PORT_LD,  1'b0, 32'h0010_0010, 4'hF, '0, 32'hCAFE_1234, 1);
    add_row(PORT_LD,  1'b0, 32'h0010_0014, 4'hF, '0, 32'h7E57_BEEF, 1);
    // Loader write and LSU read in the same cycle
    add_row(PORT_BOTH, 1'b1, 32'h0010_0004, 4'h1, 32'h0000_00C3, 32'h12A5_56C3, 1);
    // Outside the local region
    add_row(PORT_LSU, 1'b1, 32'h8000_0040, 4'h6, 32'hDEAD_BEEF, '0, 1);
    add_row(PORT_LSU, 1'b0, 32'h8000_0040, 4'hF, '0, 32'h7FFF_FFBF, 1);
    add_row(PORT_LSU, 1'b0, 32'h0020_0008, 4'hF, '0, 32'hFFDF_FFF7, 1);
    add_row(PORT_LSU, 1'b0, 32'h0000_0100, 4'hF, '0, 32'hFFFF_FEFF, 1);
    // Back-to-back local reads
    add_row(PORT_LSU, 1'b0, 32'h0010_0000, 4'hF, '0, 32'h11EE_33CC, 4);
    add_row(PORT_LSU, 1'b0, 32'h0010_0010, 4'hF, '0, 32'hCAFE_1234, 2);
    max_cycles = 20 * row_count + 10;

    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_ctrl("lsu_gnt_o", 1'b0, lsu_gnt_o);
    check_ctrl("lsu_rvalid_o", 1'b0, lsu_rvalid_o);
    check_ctrl("ext_req_o", 1'b0, ext_req_o);
    @(posedge clk);
    #2;

    for (int r = 0; r < row_count; r++)
    begin
      case (row_port[r])
        PORT_LD:
          ld_access(row_addr[r], row_we[r], row_be[r], row_wdata[r], row_exp[r]);
        PORT_LSU:
          lsu_access(row_addr[r], row_we[r], row_be[r], row_wdata[r], row_len[r], row_exp[r]);
        default:
          fork
            ld_access(row_addr[r], 1'b1, row_be[r], row_wdata[r], '0);
            lsu_access(row_addr[r], 1'b0, 4'hF, '0, 1, row_exp[r]);
          join
      endcase
    end

    $display("Run finished: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

/* verif/mem_region_assert.sv */
`timescale 1ns/1ps

module mem_region_assert
(
  input logic                  clk,
  input logic                  rst_n,
  input logic                  lsu_req_i,
  input mem_region_pkg::addr_t lsu_addr_i,
  input logic                  lsu_we_i,
  input mem_region_pkg::be_t   lsu_be_i,
  input mem_region_pkg::data_t lsu_wdata_i,
  input logic                  lsu_gnt_i,
  input logic                  ram_req_i,
  input logic                  ext_req_i,
  input logic                  ram_gnt_i,
  input logic                  ram_rvalid_i
);

  // A stalled request keeps every field
  a_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_req_i && !lsu_gnt_i) |=> (lsu_req_i && $stable(lsu_addr_i) && $stable(lsu_we_i)
                                   && $stable(lsu_be_i) && $stable(lsu_wdata_i)))
    else $error("LSU request dropped or changed while waiting for its grant");

  // RAM grants only a request steered to the RAM
  a_ram_gnt : assert property (@(posedge clk) disable iff (!rst_n)
    ram_gnt_i |-> (ram_req_i && !ext_req_i))
    else $error("RAM granted a request that was not steered to it");

  a_ram_rvalid : assert property (@(posedge clk) disable iff (!rst_n)
    ram_gnt_i |=> ram_rvalid_i)
    else $error("RAM response missing one cycle after its grant");

endmodule

bind lsu_demux mem_region_assert i_mem_region_assert
(
  .clk          ( clk          ),
  .rst_n        ( rst_n        ),
  .lsu_req_i    ( lsu_req_i    ),
  .lsu_addr_i   ( lsu_addr_i   ),
  .lsu_we_i     ( lsu_we_i     ),
  .lsu_be_i     ( lsu_be_i     ),
  .lsu_wdata_i  ( lsu_wdata_i  ),
  .lsu_gnt_i    ( lsu_gnt_o    ),
  .ram_req_i    ( ram_req_o    ),
  .ext_req_i    ( ext_req_o    ),
  .ram_gnt_i    ( ram_gnt_i    ),
  .ram_rvalid_i ( ram_rvalid_i )
);

/* logic/mem_region_top.sv */
`timescale 1ns/1ps

module mem_region_top
#(
  parameter int RAM_ADDR_W = 8
)
(
  input  logic                   clk,
  input  logic                   rst_n,

  // LSU port
  input  logic                   lsu_req_i,
  input  mem_region_pkg::addr_t  lsu_addr_i,
  input  logic                   lsu_we_i,
  input  mem_region_pkg::be_t    lsu_be_i,
  input  mem_region_pkg::data_t  lsu_wdata_i,
  output logic                   lsu_gnt_o,
  output logic                   lsu_rvalid_o,
  output mem_region_pkg::data_t  lsu_rdata_o,

  // External bus port
  output logic                   ext_req_o,
  output mem_region_pkg::addr_t  ext_addr_o,
  output logic                   ext_we_o,
  output mem_region_pkg::be_t    ext_be_o,
  output mem_region_pkg::data_t  ext_wdata_o,
  input  logic                   ext_gnt_i,
  input  logic                   ext_rvalid_i,
  input  mem_region_pkg::data_t  ext_rdata_i,

  // Loader port, word addressed and never stalled
  input  logic                   ld_req_i,
  input  logic [RAM_ADDR_W-1:0]  ld_addr_i,
  input  logic                   ld_we_i,
  input  mem_region_pkg::be_t    ld_be_i,
  input  mem_region_pkg::data_t  ld_wdata_i,
  output mem_region_pkg::data_t  ld_rdata_o
);

  // LSU to RAM mux
  logic                   ram_req;
  mem_region_pkg::addr_t  ram_addr;
  logic                   ram_we;
  mem_region_pkg::be_t    ram_be;
  mem_region_pkg::data_t  ram_wdata;
  logic                   ram_gnt;
  logic                   ram_rvalid;
  mem_region_pkg::data_t  ram_rdata;

  // RAM mux to RAM macro
  logic                   mem_en;
  logic [RAM_ADDR_W-1:0]  mem_addr;
  logic                   mem_we;
  mem_region_pkg::be_t    mem_be;
  mem_region_pkg::data_t  mem_wdata;
  mem_region_pkg::data_t  mem_rdata;

  lsu_demux i_lsu_demux
  (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),

    .lsu_req_i    ( lsu_req_i    ),
    .lsu_addr_i   ( lsu_addr_i   ),
    .lsu_we_i     ( lsu_we_i     ),
    .lsu_be_i     ( lsu_be_i     ),
    .lsu_wdata_i  ( lsu_wdata_i  ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),

    .ext_req_o    ( ext_req_o    ),
    .ext_addr_o   ( ext_addr_o   ),
    .ext_we_o     ( ext_we_o     ),
    .ext_be_o     ( ext_be_o     ),
    .ext_wdata_o  ( ext_wdata_o  ),
    .ext_gnt_i    ( ext_gnt_i    ),
    .ext_rvalid_i ( ext_rvalid_i ),
    .ext_rdata_i  ( ext_rdata_i  ),

    .ram_req_o    ( ram_req      ),
    .ram_addr_o   ( ram_addr     ),
    .ram_we_o     ( ram_we       ),
    .ram_be_o     ( ram_be       ),
    .ram_wdata_o  ( ram_wdata    ),
    .ram_gnt_i    ( ram_gnt      ),
    .ram_rvalid_i ( ram_rvalid   ),
    .ram_rdata_i  ( ram_rdata    )
  );

  data_ram_mux
  #(
    .RAM_ADDR_W ( RAM_ADDR_W )
  )
  i_data_ram_mux
  (
    .clk           ( clk        ),
    .rst_n         ( rst_n      ),

    .ld_req_i      ( ld_req_i   ),
    .ld_addr_i     ( ld_addr_i  ),
    .ld_we_i       ( ld_we_i    ),
    .ld_be_i       ( ld_be_i    ),
    .ld_wdata_i    ( ld_wdata_i ),
    .ld_rdata_o    ( ld_rdata_o ),

    .core_req_i    ( ram_req    ),
    .core_addr_i   ( ram_addr   ),
    .core_we_i     ( ram_we     ),
    .core_be_i     ( ram_be     ),
    .core_wdata_i  ( ram_wdata  ),
    .core_gnt_o    ( ram_gnt    ),
    .core_rvalid_o ( ram_rvalid ),
    .core_rdata_o  ( ram_rdata  ),

    .mem_en_o      ( mem_en     ),
    .mem_addr_o    ( mem_addr   ),
    .mem_we_o      ( mem_we     ),
    .mem_be_o      ( mem_be     ),
    .mem_wdata_o   ( mem_wdata  ),
    .mem_rdata_i   ( mem_rdata  )
  );

  data_sp_ram
  #(
    .RAM_ADDR_W ( RAM_ADDR_W )
  )
  i_data_sp_ram
  (
    .clk     ( clk       ),
    .en_i    ( mem_en    ),
    .addr_i  ( mem_addr  ),
    .we_i    ( mem_we    ),
    .be_i    ( mem_be    ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

endmodule

/* data_ram/data_ram_mux.sv */
`timescale 1ns/1ps

module data_ram_mux
#(
  parameter int RAM_ADDR_W = 8
)
(
  input  logic                   clk,
  input  logic                   rst_n,

  // Loader port, always served first
  input  logic                   ld_req_i,
  input  logic [RAM_ADDR_W-1:0]  ld_addr_i,
  input  logic                   ld_we_i,
  input  mem_region_pkg::be_t    ld_be_i,
  input  mem_region_pkg::data_t  ld_wdata_i,
  output mem_region_pkg::data_t  ld_rdata_o,

  // Core port from the LSU demux, byte addressed
  input  logic                   core_req_i,
  input  mem_region_pkg::addr_t  core_addr_i,
  input  logic                   core_we_i,
  input  mem_region_pkg::be_t    core_be_i,
  input  mem_region_pkg::data_t  core_wdata_i,
  output logic                   core_gnt_o,
  output logic                   core_rvalid_o,
  output mem_region_pkg::data_t  core_rdata_o,

  // Single RAM port
  output logic                   mem_en_o,
  output logic [RAM_ADDR_W-1:0]  mem_addr_o,
  output logic                   mem_we_o,
  output mem_region_pkg::be_t    mem_be_o,
  output mem_region_pkg::data_t  mem_wdata_o,
  input  mem_region_pkg::data_t  mem_rdata_i
);

  logic [RAM_ADDR_W-1:0] core_word_addr;
  logic                  ld_served_q;
  logic                  core_served_q;

  // Drop the byte offset of the core address
  assign core_word_addr = core_addr_i[RAM_ADDR_W+1:2];

  // Loader takes priority, core only when the loader is idle
  assign core_gnt_o = core_req_i & ~ld_req_i;

  assign mem_en_o = ld_req_i | core_req_i;

  always_comb
  begin
    if (ld_req_i)
    begin
      mem_addr_o  = ld_addr_i;
      mem_we_o    = ld_we_i;
      mem_be_o    = ld_be_i;
      mem_wdata_o = ld_wdata_i;
    end
    else
    begin
      mem_addr_o  = core_word_addr;
      mem_we_o    = core_we_i;
      mem_be_o    = core_be_i;
      mem_wdata_o = core_wdata_i;
    end
  end

  // Track who owned the RAM in the previous cycle
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      ld_served_q   <= 1'b0;
      core_served_q <= 1'b0;
    end
    else
    begin
      ld_served_q   <= ld_req_i;
      core_served_q <= core_gnt_o;
    end
  end

  // One response per grant, exactly one cycle later
  assign core_rvalid_o = core_served_q;

  // Read data goes only to the previous owner
  assign ld_rdata_o   = ld_served_q   ? mem_rdata_i : '0;
  assign core_rdata_o = core_served_q ? mem_rdata_i : '0;

endmodule

/* data_ram/data_sp_ram.sv */
`timescale 1ns/1ps

module data_sp_ram
#(
  parameter int RAM_ADDR_W = 8
)
(
  input  logic                   clk,
  input  logic                   en_i,
  input  logic [RAM_ADDR_W-1:0]  addr_i,
  input  logic                   we_i,
  input  mem_region_pkg::be_t    be_i,
  input  mem_region_pkg::data_t  wdata_i,
  output mem_region_pkg::data_t  rdata_o
);

  localparam int NUM_WORDS = 2 ** RAM_ADDR_W;

  mem_region_pkg::data_t mem [NUM_WORDS];

  logic wr_en;
  logic rd_en;

  assign wr_en = en_i & we_i;
  assign rd_en = en_i & ~we_i;

  // Only the enabled byte lanes are written
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      for (int b = 0; b < mem_region_pkg::BE_W; b++)
      begin
        if (be_i[b])
          mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  // Read data held until the next read
  always_ff @(posedge clk)
  begin
    if (rd_en)
      rdata_o <= mem[addr_i];
  end

endmodule

/* logic/lsu_demux.sv */
`timescale 1ns/1ps

module lsu_demux
(
  input  logic                   clk,
  input  logic                   rst_n,

  // LSU side
  input  logic                   lsu_req_i,
  input  mem_region_pkg::addr_t  lsu_addr_i,
  input  logic                   lsu_we_i,
  input  mem_region_pkg::be_t    lsu_be_i,
  input  mem_region_pkg::data_t  lsu_wdata_i,
  output logic                   lsu_gnt_o,
  output logic                   lsu_rvalid_o,
  output mem_region_pkg::data_t  lsu_rdata_o,

  // External bus side
  output logic                   ext_req_o,
  output mem_region_pkg::addr_t  ext_addr_o,
  output logic                   ext_we_o,
  output mem_region_pkg::be_t    ext_be_o,
  output mem_region_pkg::data_t  ext_wdata_o,
  input  logic                   ext_gnt_i,
  input  logic                   ext_rvalid_i,
  input  mem_region_pkg::data_t  ext_rdata_i,

  // Local RAM side
  output logic                   ram_req_o,
  output mem_region_pkg::addr_t  ram_addr_o,
  output logic                   ram_we_o,
  output mem_region_pkg::be_t    ram_be_o,
  output mem_region_pkg::data_t  ram_wdata_o,
  input  logic                   ram_gnt_i,
  input  logic                   ram_rvalid_i,
  input  mem_region_pkg::data_t  ram_rdata_i
);

  logic [mem_region_pkg::TAG_W-1:0] lsu_tag;
  logic                             is_local;
  mem_region_pkg::resp_src_e        resp_src_q;
  mem_region_pkg::resp_src_e        resp_src_d;

  // Region decode on the top address bits
  assign lsu_tag  = lsu_addr_i[mem_region_pkg::ADDR_W-1 -: mem_region_pkg::TAG_W];
  assign is_local = (lsu_tag == mem_region_pkg::LOCAL_TAG);

  // Only one of the two targets sees the request
  assign ram_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;

  // Request fields fan out unchanged to both targets
  assign ram_addr_o  = lsu_addr_i;
  assign ram_we_o    = lsu_we_i;
  assign ram_be_o    = lsu_be_i;
  assign ram_wdata_o = lsu_wdata_i;

  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  // Grant from the selected target, remember it once accepted
  always_comb
  begin
    resp_src_d = resp_src_q;
    lsu_gnt_o  = 1'b0;

    if (ext_req_o)
    begin
      lsu_gnt_o = ext_gnt_i;
      if (ext_gnt_i)
        resp_src_d = mem_region_pkg::RESP_EXT;
    end
    else if (ram_req_o)
    begin
      lsu_gnt_o = ram_gnt_i;
      if (ram_gnt_i)
        resp_src_d = mem_region_pkg::RESP_RAM;
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      resp_src_q <= mem_region_pkg::RESP_RAM;
    else
      resp_src_q <= resp_src_d;
  end

  // Response path back to the LSU
  assign lsu_rdata_o  = (resp_src_q == mem_region_pkg::RESP_EXT) ? ext_rdata_i : ram_rdata_i;
  assign lsu_rvalid_o = ext_rvalid_i | ram_rvalid_i;

endmodule

/* common/mem_region_pkg.sv */
package mem_region_pkg;

  // Bus widths shared by the LSU, external and RAM ports
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // Upper address bits that select the region
  localparam int TAG_W = 12;

  // Tag of the local data RAM, everything else goes external
  localparam logic [TAG_W-1:0] LOCAL_TAG = 12'h001;

  // Byte address as issued by the LSU
  typedef logic [ADDR_W-1:0] addr_t;

  // One data word
  typedef logic [DATA_W-1:0] data_t;

  // One enable bit per byte lane
  typedef logic [BE_W-1:0] be_t;

  // Where the next LSU response comes from
  typedef enum logic
  {
    RESP_RAM = 1'b0,
    RESP_EXT = 1'b1
  } resp_src_e;

endpackage
